/* rtl/rca_cfg_defs.svh */
`ifndef RCA_CFG_DEFS_SVH
`define RCA_CFG_DEFS_SVH

// Fabric dimensions
`define RCA_NUM_RCAS 4
`define RCA_NUM_READ_PORTS 2
`define RCA_NUM_WRITE_PORTS 2

// Grid crossbar with one mux per grid cell input
`define RCA_NUM_GRID_MUXES 16
`define RCA_GRID_MUX_INPUTS 8
`define RCA_GRID_NUM_ROWS 4

// IO unit crossbar with one unit per grid row
`define RCA_IO_MUX_INPUTS 4

// Cycles the crossbars need after a write before the host may go on
`define RCA_SETTLE_CYCLES 3

// Command opcodes
`define RCA_OP_SRC_FB 3'd0
`define RCA_OP_DEST_FB 3'd1
`define RCA_OP_DEST_NFB 3'd2
`define RCA_OP_GRID 3'd3
`define RCA_OP_IO 3'd4
`define RCA_OP_RESULT 3'd5
`define RCA_OP_IO_USE 3'd6
// Non-feedback set has no source addresses so this code is illegal
`define RCA_OP_SRC_NFB 3'd7

`endif

/* rtl/rca_cfg_pkg.sv */
`include "rca_cfg_defs.svh"

package rca_cfg_pkg;

    // Command fields
    typedef logic [2:0] cfg_op_t;
    typedef logic [$clog2(`RCA_NUM_RCAS)-1:0] rca_id_t;
    typedef logic [$clog2(`RCA_NUM_GRID_MUXES)-1:0] cfg_index_t;
    typedef logic [4:0] cfg_value_t;

    // Table entries
    typedef logic [4:0] reg_addr_t;
    typedef logic [$clog2(`RCA_GRID_MUX_INPUTS)-1:0] grid_sel_t;
    typedef logic [$clog2(`RCA_IO_MUX_INPUTS)-1:0] io_sel_t;
    typedef logic [$clog2(`RCA_GRID_NUM_ROWS)-1:0] row_sel_t;
    typedef logic [`RCA_GRID_NUM_ROWS-1:0] row_mask_t;

    // Settle delay counter
    typedef logic [$clog2(`RCA_SETTLE_CYCLES)-1:0] settle_cnt_t;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_WRITE,
        LD_SETTLE,
        LD_ACK
    } loader_state_t;

endpackage

/* rtl/cfg_settle_timer.sv */
`include "rca_cfg_defs.svh"

module cfg_settle_timer (
    input  logic clk,
    input  logic rst,
    input  logic settle_start,
    output logic settle_done
);

    rca_cfg_pkg::settle_cnt_t cnt;
    logic busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            busy <= 1'b0;
        end else if (settle_start) begin
            cnt  <= rca_cfg_pkg::settle_cnt_t'(`RCA_SETTLE_CYCLES - 1);
            busy <= 1'b1;
        end else if (busy) begin
            if (cnt == '0) busy <= 1'b0;
            else cnt <= cnt - 1'b1;
        end
    end

    // Last cycle of the count is the done cycle
    assign settle_done = busy && (cnt == '0);

    // Loader only starts a new settle after the previous one finished
    start_while_busy: assert property (@(posedge clk) disable iff (rst) settle_start |-> !busy)
        else $error("settle_start arrived while the settle timer was running");

endmodule

/* rtl/cfg_loader_fsm.sv */
`include "rca_cfg_defs.svh"

module cfg_loader_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_req,
    input  rca_cfg_pkg::cfg_op_t    cmd_op,
    input  rca_cfg_pkg::rca_id_t    cmd_rca,
    input  rca_cfg_pkg::cfg_index_t cmd_index,
    input  rca_cfg_pkg::cfg_value_t cmd_value,
    input  logic                    settle_done,
    output logic                    cmd_ack,
    output logic                    cmd_err,
    output logic                    settle_start,
    output logic                    src_fb_wr_en,
    output logic                    dest_fb_wr_en,
    output logic                    dest_nfb_wr_en,
    output logic                    grid_wr_en,
    output logic                    io_wr_en,
    output logic                    result_wr_en,
    output logic                    io_use_wr_en,
    output rca_cfg_pkg::rca_id_t    wr_rca,
    output rca_cfg_pkg::cfg_index_t wr_index,
    output rca_cfg_pkg::cfg_value_t wr_value
);

    rca_cfg_pkg::loader_state_t state;
    rca_cfg_pkg::loader_state_t state_next;
    rca_cfg_pkg::cfg_op_t       op_q;
    logic                       accept;
    logic                       in_write;
    logic                       op_illegal;

    assign accept   = (state == rca_cfg_pkg::LD_IDLE) && cmd_req;
    assign in_write = (state == rca_cfg_pkg::LD_WRITE);

    always_ff @(posedge clk) begin
        if (rst) state <= rca_cfg_pkg::LD_IDLE;
        else state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            rca_cfg_pkg::LD_IDLE:   if (cmd_req) state_next = rca_cfg_pkg::LD_WRITE;
            rca_cfg_pkg::LD_WRITE:  state_next = rca_cfg_pkg::LD_SETTLE;
            rca_cfg_pkg::LD_SETTLE: if (settle_done) state_next = rca_cfg_pkg::LD_ACK;
            // Held here for as long as the host keeps req high
            rca_cfg_pkg::LD_ACK:    if (!cmd_req) state_next = rca_cfg_pkg::LD_IDLE;
            default:                state_next = rca_cfg_pkg::LD_IDLE;
        endcase
    end

    // Command captured once on accept and held for the write
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q     <= cmd_op;
            wr_rca   <= cmd_rca;
            wr_index <= cmd_index;
            wr_value <= cmd_value;
        end
    end

    // Opcode decode into one table enable
    always_comb begin
        src_fb_wr_en   = 1'b0;
        dest_fb_wr_en  = 1'b0;
        dest_nfb_wr_en = 1'b0;
        grid_wr_en     = 1'b0;
        io_wr_en       = 1'b0;
        result_wr_en   = 1'b0;
        io_use_wr_en   = 1'b0;
        op_illegal     = 1'b0;
        case (op_q)
            `RCA_OP_SRC_FB:   src_fb_wr_en   = in_write;
            `RCA_OP_DEST_FB:  dest_fb_wr_en  = in_write;
            `RCA_OP_DEST_NFB: dest_nfb_wr_en = in_write;
            `RCA_OP_GRID:     grid_wr_en     = in_write;
            `RCA_OP_IO:       io_wr_en       = in_write;
            `RCA_OP_RESULT:   result_wr_en   = in_write;
            `RCA_OP_IO_USE:   io_use_wr_en   = in_write;
            default:          op_illegal     = 1'b1;
        endcase
    end

    // Illegal commands still settle so the ack timing never changes
    assign settle_start = in_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_ack <= 1'b0;
            cmd_err <= 1'b0;
        end else begin
            cmd_ack <= (state == rca_cfg_pkg::LD_ACK) && cmd_req;
            if (accept) cmd_err <= 1'b0;
            else if (in_write) cmd_err <= op_illegal;
        end
    end

    // Ack only follows a finished settle and a request still held by the host
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(cmd_ack) |-> $past(cmd_req) && $past(settle_done, 2))
        else $error("cmd_ack rose without a pending cmd_req after the settle delay");

endmodule

/* rtl/rca_config_regs.sv */
`include "rca_cfg_defs.svh"

module rca_config_regs (
    input  logic                    clk,
    input  logic                    rst,

    // Write side, driven by the loader
    input  logic                    src_fb_wr_en,
    input  logic                    dest_fb_wr_en,
    input  logic                    dest_nfb_wr_en,
    input  logic                    grid_wr_en,
    input  logic                    io_wr_en,
    input  logic                    result_wr_en,
    input  logic                    io_use_wr_en,
    input  rca_cfg_pkg::rca_id_t    wr_rca,
    input  rca_cfg_pkg::cfg_index_t wr_index,
    input  rca_cfg_pkg::cfg_value_t wr_value,

    // Read side, seen by the fabric
    input  rca_cfg_pkg::rca_id_t    rca_sel,
    input  logic                    rca_use_fb_instr,
    input  rca_cfg_pkg::cfg_index_t grid_mux_addr,
    output rca_cfg_pkg::reg_addr_t  rca_cpu_src_reg_addrs [`RCA_NUM_READ_PORTS],
    output rca_cfg_pkg::reg_addr_t  rca_cpu_dest_reg_addrs [`RCA_NUM_WRITE_PORTS],
    output rca_cfg_pkg::grid_sel_t  curr_grid_mux_sel,
    output rca_cfg_pkg::io_sel_t    curr_io_mux_sels [`RCA_GRID_NUM_ROWS],
    output rca_cfg_pkg::row_sel_t   curr_rca_result_mux_sel [`RCA_NUM_WRITE_PORTS],
    output rca_cfg_pkg::row_mask_t  curr_rca_io_inp_use
);

    localparam int RD_PORT_W = $clog2(`RCA_NUM_READ_PORTS);
    localparam int WR_PORT_W = $clog2(`RCA_NUM_WRITE_PORTS);
    localparam int ROW_W     = $clog2(`RCA_GRID_NUM_ROWS);

    rca_cfg_pkg::reg_addr_t  src_addrs   [`RCA_NUM_RCAS][`RCA_NUM_READ_PORTS];
    rca_cfg_pkg::reg_addr_t  dest_fb     [`RCA_NUM_RCAS][`RCA_NUM_WRITE_PORTS];
    rca_cfg_pkg::reg_addr_t  dest_nfb    [`RCA_NUM_RCAS][`RCA_NUM_WRITE_PORTS];
    rca_cfg_pkg::grid_sel_t  grid_sels   [`RCA_NUM_GRID_MUXES];
    rca_cfg_pkg::io_sel_t    io_sels     [`RCA_GRID_NUM_ROWS];
    rca_cfg_pkg::row_sel_t   result_sels [`RCA_NUM_RCAS][`RCA_NUM_WRITE_PORTS];
    rca_cfg_pkg::row_mask_t  io_use      [`RCA_NUM_RCAS];

    // CPU register addresses, source set only exists for feedback
    always_ff @(posedge clk) begin
        if (rst) begin
            src_addrs <= '{default: '0};
            dest_fb   <= '{default: '0};
            dest_nfb  <= '{default: '0};
        end else begin
            if (src_fb_wr_en)
                src_addrs[wr_rca][wr_index[RD_PORT_W-1:0]] <= wr_value;
            if (dest_fb_wr_en)
                dest_fb[wr_rca][wr_index[WR_PORT_W-1:0]] <= wr_value;
            if (dest_nfb_wr_en)
                dest_nfb[wr_rca][wr_index[WR_PORT_W-1:0]] <= wr_value;
        end
    end

    // Grid crossbar selects, full index range
    always_ff @(posedge clk) begin
        if (rst) grid_sels <= '{default: '0};
        else if (grid_wr_en) grid_sels[wr_index] <= rca_cfg_pkg::grid_sel_t'(wr_value);
    end

    // IO unit selects, one per row
    always_ff @(posedge clk) begin
        if (rst) io_sels <= '{default: '0};
        else if (io_wr_en) io_sels[wr_index[ROW_W-1:0]] <= rca_cfg_pkg::io_sel_t'(wr_value);
    end

    // Result crossbar row per accelerator write port
    always_ff @(posedge clk) begin
        if (rst) begin
            result_sels <= '{default: '0};
        end else if (result_wr_en) begin
            result_sels[wr_rca][wr_index[WR_PORT_W-1:0]] <=
                rca_cfg_pkg::row_sel_t'(wr_value);
        end
    end

    // Which IO input units feed each accelerator
    always_ff @(posedge clk) begin
        if (rst) io_use <= '{default: '0};
        else if (io_use_wr_en) io_use[wr_rca] <= rca_cfg_pkg::row_mask_t'(wr_value);
    end

    always_comb begin
        for (int p = 0; p < `RCA_NUM_READ_PORTS; p++) begin
            if (rca_use_fb_instr) rca_cpu_src_reg_addrs[p] = src_addrs[rca_sel][p];
            else rca_cpu_src_reg_addrs[p] = '0;
        end
        for (int p = 0; p < `RCA_NUM_WRITE_PORTS; p++) begin
            if (rca_use_fb_instr) rca_cpu_dest_reg_addrs[p] = dest_fb[rca_sel][p];
            else rca_cpu_dest_reg_addrs[p] = dest_nfb[rca_sel][p];
        end
    end

    assign curr_grid_mux_sel       = grid_sels[grid_mux_addr];
    assign curr_io_mux_sels        = io_sels;
    assign curr_rca_result_mux_sel = result_sels[rca_sel];
    assign curr_rca_io_inp_use     = io_use[rca_sel];

    // Loader decode has to stay one-hot across all tables
    single_table_write: assert property (@(posedge clk) disable iff (rst)
        $onehot0({src_fb_wr_en, dest_fb_wr_en, dest_nfb_wr_en, grid_wr_en,
                  io_wr_en, result_wr_en, io_use_wr_en}))
        else $error("More than one configuration table written in one cycle");

endmodule

/* rtl/rca_cfg_top.sv */
`include "rca_cfg_defs.svh"

module rca_cfg_top (
    input  logic                    clk,
    input  logic                    rst,

    // Host command handshake
    input  logic                    cmd_req,
    input  rca_cfg_pkg::cfg_op_t    cmd_op,
    input  rca_cfg_pkg::rca_id_t    cmd_rca,
    input  rca_cfg_pkg::cfg_index_t cmd_index,
    input  rca_cfg_pkg::cfg_value_t cmd_value,
    output logic                    cmd_ack,
    output logic                    cmd_err,

    // Fabric read side
    input  rca_cfg_pkg::rca_id_t    rca_sel,
    input  logic                    rca_use_fb_instr,
    input  rca_cfg_pkg::cfg_index_t grid_mux_addr,
    output rca_cfg_pkg::reg_addr_t  rca_cpu_src_reg_addrs [`RCA_NUM_READ_PORTS],
    output rca_cfg_pkg::reg_addr_t  rca_cpu_dest_reg_addrs [`RCA_NUM_WRITE_PORTS],
    output rca_cfg_pkg::grid_sel_t  curr_grid_mux_sel,
    output rca_cfg_pkg::io_sel_t    curr_io_mux_sels [`RCA_GRID_NUM_ROWS],
    output rca_cfg_pkg::row_sel_t   curr_rca_result_mux_sel [`RCA_NUM_WRITE_PORTS],
    output rca_cfg_pkg::row_mask_t  curr_rca_io_inp_use
);

    logic                    settle_start;
    logic                    settle_done;
    logic                    src_fb_wr_en;
    logic                    dest_fb_wr_en;
    logic                    dest_nfb_wr_en;
    logic                    grid_wr_en;
    logic                    io_wr_en;
    logic                    result_wr_en;
    logic                    io_use_wr_en;
    rca_cfg_pkg::rca_id_t    wr_rca;
    rca_cfg_pkg::cfg_index_t wr_index;
    rca_cfg_pkg::cfg_value_t wr_value;

    cfg_loader_fsm u_loader (
        .clk, .rst, .cmd_req, .cmd_op, .cmd_rca, .cmd_index, .cmd_value,
        .settle_done, .cmd_ack, .cmd_err, .settle_start,
        .src_fb_wr_en, .dest_fb_wr_en, .dest_nfb_wr_en, .grid_wr_en,
        .io_wr_en, .result_wr_en, .io_use_wr_en, .wr_rca, .wr_index, .wr_value
    );

    cfg_settle_timer u_settle (.clk, .rst, .settle_start, .settle_done);

    rca_config_regs u_regs (
        .clk, .rst,
        .src_fb_wr_en, .dest_fb_wr_en, .dest_nfb_wr_en, .grid_wr_en,
        .io_wr_en, .result_wr_en, .io_use_wr_en, .wr_rca, .wr_index, .wr_value,
        .rca_sel, .rca_use_fb_instr, .grid_mux_addr,
        .rca_cpu_src_reg_addrs, .rca_cpu_dest_reg_addrs, .curr_grid_mux_sel,
        .curr_io_mux_sels, .curr_rca_result_mux_sel, .curr_rca_io_inp_use
    );

endmodule

/* verification/rca_cfg_tb.sv */
`include "rca_cfg_defs.svh"

module rca_cfg_tb;

    localparam int DRIVE_DLY   = 1;
    localparam int SAMPLE_DLY  = 10;
    localparam int ACK_LATENCY = `RCA_SETTLE_CYCLES + 2;
    localparam int WAIT_LIMIT  = 50;

    logic                    clk;
    logic                    rst;
    logic                    cmd_req;
    rca_cfg_pkg::cfg_op_t    cmd_op;
    rca_cfg_pkg::rca_id_t    cmd_rca;
    rca_cfg_pkg::cfg_index_t cmd_index;
    rca_cfg_pkg::cfg_value_t cmd_value;
    logic                    cmd_ack;
    logic                    cmd_err;
    rca_cfg_pkg::rca_id_t    rca_sel;
    logic                    rca_use_fb_instr;
    rca_cfg_pkg::cfg_index_t grid_mux_addr;
    rca_cfg_pkg::reg_addr_t  rca_cpu_src_reg_addrs [`RCA_NUM_READ_PORTS];
    rca_cfg_pkg::reg_addr_t  rca_cpu_dest_reg_addrs [`RCA_NUM_WRITE_PORTS];
    rca_cfg_pkg::grid_sel_t  curr_grid_mux_sel;
    rca_cfg_pkg::io_sel_t    curr_io_mux_sels [`RCA_GRID_NUM_ROWS];
    rca_cfg_pkg::row_sel_t   curr_rca_result_mux_sel [`RCA_NUM_WRITE_PORTS];
    rca_cfg_pkg::row_mask_t  curr_rca_io_inp_use;

    // Expected table contents
    rca_cfg_pkg::reg_addr_t  m_src [`RCA_NUM_RCAS][`RCA_NUM_READ_PORTS];
    rca_cfg_pkg::reg_addr_t  m_dest_fb [`RCA_NUM_RCAS][`RCA_NUM_WRITE_PORTS];
    rca_cfg_pkg::reg_addr_t  m_dest_nfb [`RCA_NUM_RCAS][`RCA_NUM_WRITE_PORTS];
    rca_cfg_pkg::grid_sel_t  m_grid [`RCA_NUM_GRID_MUXES];
    rca_cfg_pkg::io_sel_t    m_io [`RCA_GRID_NUM_ROWS];
    rca_cfg_pkg::row_sel_t   m_result [`RCA_NUM_RCAS][`RCA_NUM_WRITE_PORTS];
    rca_cfg_pkg::row_mask_t  m_io_use [`RCA_NUM_RCAS];

    int seed;
    int errors;
    int checks;

    rca_cfg_top uut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // Only the low bits that fit each table are kept
    task automatic model_write(input rca_cfg_pkg::cfg_op_t op, input int rca, input int idx,
                               input int val);
        case (op)
            `RCA_OP_SRC_FB:   m_src[rca][idx % 2] = val[4:0];
            `RCA_OP_DEST_FB:  m_dest_fb[rca][idx % 2] = val[4:0];
            `RCA_OP_DEST_NFB: m_dest_nfb[rca][idx % 2] = val[4:0];
            `RCA_OP_GRID:     m_grid[idx % 16] = val[2:0];
            `RCA_OP_IO:       m_io[idx % 4] = val[1:0];
            `RCA_OP_RESULT:   m_result[rca][idx % 2] = val[1:0];
            `RCA_OP_IO_USE:   m_io_use[rca] = val[3:0];
            default: ;
        endcase
    endtask

    // Full four-phase handshake, hold keeps req high for extra cycles after the ack
    task automatic send_cmd(input rca_cfg_pkg::cfg_op_t op, input int rca, input int idx,
                            input int val, input int hold);
        int cycles;
        @(posedge clk);
        #DRIVE_DLY;
        cmd_op    = op;
        cmd_rca   = rca_cfg_pkg::rca_id_t'(rca);
        cmd_index = rca_cfg_pkg::cfg_index_t'(idx);
        cmd_value = rca_cfg_pkg::cfg_value_t'(val);
        cmd_req   = 1'b1;
        // This edge samples the request
        @(posedge clk);
        #DRIVE_DLY;
        cycles = 0;
        while (!cmd_ack && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end
        if (!cmd_ack) begin
            $display("Timed out waiting for cmd_ack to rise");
            errors++;
        end else begin
            expect_equal("cmd_ack latency", 32'(cycles), 32'(ACK_LATENCY));
            expect_equal("cmd_err", 32'(cmd_err), 32'(op == `RCA_OP_SRC_NFB));
        end
        for (int h = 0; h < hold; h++) begin
            @(posedge clk);
            #DRIVE_DLY;
            expect_equal("cmd_ack", 32'(cmd_ack), 32'd1);
        end
        cmd_req = 1'b0;
        cycles = 0;
        while (cmd_ack && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end
        if (cmd_ack) begin
            $display("Timed out waiting for cmd_ack to fall");
            errors++;
        end
        model_write(op, rca, idx, val);
    endtask

    task automatic check_rca_view(input int sel, input logic fb);
        @(posedge clk);
        #DRIVE_DLY;
        rca_sel          = rca_cfg_pkg::rca_id_t'(sel);
        rca_use_fb_instr = fb;
        #SAMPLE_DLY;
        for (int p = 0; p < `RCA_NUM_READ_PORTS; p++)
            expect_equal($sformatf("rca_cpu_src_reg_addrs[%0d] sel %0d fb %0d", p, sel, fb),
                         32'(rca_cpu_src_reg_addrs[p]), 32'(fb ? m_src[sel][p] : 5'd0));
        for (int p = 0; p < `RCA_NUM_WRITE_PORTS; p++) begin
            expect_equal($sformatf("rca_cpu_dest_reg_addrs[%0d] sel %0d fb %0d", p, sel, fb),
                         32'(rca_cpu_dest_reg_addrs[p]),
                         32'(fb ? m_dest_fb[sel][p] : m_dest_nfb[sel][p]));
            expect_equal($sformatf("curr_rca_result_mux_sel[%0d] sel %0d", p, sel),
                         32'(curr_rca_result_mux_sel[p]), 32'(m_result[sel][p]));
        end
        expect_equal($sformatf("curr_rca_io_inp_use sel %0d", sel),
                     32'(curr_rca_io_inp_use), 32'(m_io_use[sel]));
        for (int r = 0; r < `RCA_GRID_NUM_ROWS; r++)
            expect_equal($sformatf("curr_io_mux_sels[%0d]", r),
                         32'(curr_io_mux_sels[r]), 32'(m_io[r]));
    endtask

    task automatic check_all_tables();
        for (int s = 0; s < `RCA_NUM_RCAS; s++) begin
            check_rca_view(s, 1'b1);
            check_rca_view(s, 1'b0);
        end
        for (int a = 0; a < `RCA_NUM_GRID_MUXES; a++) begin
            @(posedge clk);
            #DRIVE_DLY;
            grid_mux_addr = rca_cfg_pkg::cfg_index_t'(a);
            #SAMPLE_DLY;
            expect_equal($sformatf("curr_grid_mux_sel addr %0d", a),
                         32'(curr_grid_mux_sel), 32'(m_grid[a]));
        end
    endtask

    task automatic test_reset_state();
        expect_equal("cmd_ack", 32'(cmd_ack), 32'd0);
        expect_equal("cmd_err", 32'(cmd_err), 32'd0);
        check_all_tables();
    endtask

    // Back-pressure for four cycles, then a plain handshake
    task automatic test_handshake();
        send_cmd(`RCA_OP_DEST_NFB, 3, 1, 5'h11, 4);
        send_cmd(`RCA_OP_SRC_FB, 3, 0, 5'h0a, 0);
        check_rca_view(3, 1'b1);
        check_rca_view(3, 1'b0);
    endtask

    task automatic test_fb_select();
        for (int r = 0; r < `RCA_NUM_RCAS; r += 2) begin
            for (int p = 0; p < 2; p++) begin
                send_cmd(`RCA_OP_SRC_FB, r, p, $random(seed) & 31, 0);
                send_cmd(`RCA_OP_DEST_FB, r, p, $random(seed) & 31, 0);
                send_cmd(`RCA_OP_DEST_NFB, r, p, $random(seed) & 31, 0);
            end
        end
        check_all_tables();
    endtask

    task automatic test_crossbars();
        for (int a = 0; a < `RCA_NUM_GRID_MUXES; a++)
            send_cmd(`RCA_OP_GRID, 0, a, $random(seed) & 31, 0);
        for (int r = 0; r < `RCA_GRID_NUM_ROWS; r++)
            send_cmd(`RCA_OP_IO, 0, r, $random(seed) & 31, 0);
        for (int r = 0; r < `RCA_NUM_RCAS; r++) begin
            send_cmd(`RCA_OP_RESULT, r, 0, $random(seed) & 31, 0);
            send_cmd(`RCA_OP_RESULT, r, 1, $random(seed) & 31, 0);
        end
        check_all_tables();
    endtask

    task automatic test_io_use();
        for (int r = 0; r < `RCA_NUM_RCAS; r++)
            send_cmd(`RCA_OP_IO_USE, r, 0, $random(seed) & 31, 0);
        check_all_tables();
        // Rewrite one accelerator only
        send_cmd(`RCA_OP_IO_USE, 1, 0, (m_io_use[1] ^ 4'hf), 0);
        check_all_tables();
    endtask

    task automatic test_illegal_cmd();
        send_cmd(`RCA_OP_SRC_NFB, 1, 0, 5'h1f, 0);
        check_all_tables();
        send_cmd(`RCA_OP_GRID, 0, 5, 5'h06, 0);
        check_all_tables();
    endtask

    initial begin
        seed = 87162;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        cmd_req = 1'b0;
        cmd_op = '0;
        cmd_rca = '0;
        cmd_index = '0;
        cmd_value = '0;
        rca_sel = '0;
        rca_use_fb_instr = 1'b0;
        grid_mux_addr = '0;
        m_src = '{default: '0};
        m_dest_fb = '{default: '0};
        m_dest_nfb = '{default: '0};
        m_grid = '{default: '0};
        m_io = '{default: '0};
        m_result = '{default: '0};
        m_io_use = '{default: '0};
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        test_reset_state();
        test_handshake();
        test_fb_select();
        test_crossbars();
        test_io_use();
        test_illegal_cmd();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* rca_cfg.f */
+incdir+rtl
rtl/rca_cfg_pkg.sv
rtl/cfg_settle_timer.sv
rtl/cfg_loader_fsm.sv
rtl/rca_config_regs.sv
rtl/rca_cfg_top.sv
verification/rca_cfg_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= rca_cfg_tb
FILELIST   ?= rca_cfg.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
